/* Bender.yml */
package:
  name: tl_bram_subsystem

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/tl_pkg.sv
      - src/bram_pkg.sv
      - src/tl_socket_1n.sv
      - src/tl_adapter_bram.sv
      - src/tl_bram_subsystem.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tl_bram_subsystem_chk.sv
      - sim/tb_tl_bram_subsystem.sv

/* all.f */
+incdir+src
src/tl_pkg.sv
src/bram_pkg.sv
src/tl_socket_1n.sv
src/tl_adapter_bram.sv
src/tl_bram_subsystem.sv
sim/tl_bram_subsystem_chk.sv
sim/tb_tl_bram_subsystem.sv

/* sim/tb_tl_bram_subsystem.sv */
/*
 * Testbench for the TileLink-UL to BRAM subsystem: BRAM models, directed
 * and random requests, and a scoreboard keyed by source tag.
 */

`timescale 1ns/1ps

`include "tl_defines.svh"

module tb_tl_bram_subsystem;

  import tl_pkg::*;
  import bram_pkg::*;

  localparam int MAX_CYCLES = 3000;
  localparam int NUM_TAGS   = 1 << `TL_SOURCE_WIDTH;

  logic       clk_i;
  logic       reset_i;
  logic       a_valid_i;
  logic       a_ready_o;
  tl_a_op_e   a_opcode_i;
  tl_addr_t   a_address_i;
  tl_mask_t   a_mask_i;
  tl_data_t   a_data_i;
  tl_source_t a_source_i;
  logic       d_valid_o;
  logic       d_ready_i;
  tl_d_op_e   d_opcode_o;
  tl_source_t d_source_o;
  tl_data_t   d_data_o;
  logic       mem_en_o;
  logic       mem_we_o;
  bram_addr_t mem_addr_o;
  tl_mask_t   mem_wmask_o;
  tl_data_t   mem_wdata_o;
  tl_data_t   mem_rdata_i;
  logic       io_en_o;
  logic       io_we_o;
  bram_addr_t io_addr_o;
  tl_mask_t   io_wmask_o;
  tl_data_t   io_wdata_o;
  tl_data_t   io_rdata_i;

  tl_data_t   mem_array [bram_addr_t];
  tl_data_t   io_array  [bram_addr_t];
  tl_data_t   ref_mem   [bram_addr_t];
  bit         pending    [NUM_TAGS];
  tl_d_op_e   exp_opcode [NUM_TAGS];
  tl_data_t   exp_data   [NUM_TAGS];
  tl_source_t next_tag;
  logic       a_accepted;
  logic       ready_draw;
  int         check_errors;
  int         req_count;
  int         resp_count;
  int         cycle_count;
  integer     seed;

  tl_bram_subsystem i_tl_bram_subsystem (.*);

  always #20 clk_i = ~clk_i;

  function automatic tl_data_t fill_word(bram_addr_t addr);
    return {addr[10:0], addr} ^ 64'h5a5a_0000_0000_a5a5;
  endfunction

  function automatic tl_data_t merge_bytes(tl_data_t old_word, tl_data_t new_word,
                                           tl_mask_t mask);
    tl_data_t result;
    result = old_word;
    for (int i = 0; i < `TL_DATA_WIDTH / 8; i++) begin
      if (mask[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  // The IO window runs from IO_BASE up to IO_BASE with all mask bits set.
  function automatic bit in_io_window(tl_addr_t addr);
    return (addr >= `IO_BASE) && (addr <= (`IO_BASE | `IO_MASK));
  endfunction

  task automatic expect_true(input bit cond, input string msg);
    assert (cond) else begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
    end
  endtask

  // Issues one request at a falling edge and returns once it is taken.
  task automatic send_request(input tl_a_op_e op, input tl_addr_t addr,
                              input tl_mask_t mask, input tl_data_t data);
    bram_addr_t word;
    tl_source_t tag;
    tl_data_t   old_word;
    word     = addr[`TL_ADDR_WIDTH-1:3];
    tag      = next_tag;
    next_tag = next_tag + 1'b1;
    old_word = ref_mem.exists(word) ? ref_mem[word] : fill_word(word);
    case (op)
      TL_GET: begin
        exp_opcode[tag] = TL_ACCESS_ACK_DATA;
        exp_data[tag]   = old_word;
      end
      TL_PUT_FULL_DATA: begin
        exp_opcode[tag] = TL_ACCESS_ACK;
        ref_mem[word]   = data;
      end
      default: begin
        exp_opcode[tag] = TL_ACCESS_ACK;
        ref_mem[word]   = merge_bytes(old_word, data, mask);
      end
    endcase
    expect_true(!pending[tag], $sformatf("source %0d reused while outstanding", tag));
    pending[tag] = 1'b1;
    req_count++;
    a_valid_i   = 1'b1;
    a_opcode_i  = op;
    a_address_i = addr;
    a_mask_i    = mask;
    a_data_i    = data;
    a_source_i  = tag;
    do @(negedge clk_i); while (!a_accepted);
    a_valid_i = 1'b0;
  endtask

  // Behavioral BRAMs return read data one cycle after the enabled access.
  always @(posedge clk_i) begin
    if (mem_en_o) begin
      if (!mem_array.exists(mem_addr_o)) begin
        mem_array[mem_addr_o] = fill_word(mem_addr_o);
      end
      if (mem_we_o) begin
        mem_array[mem_addr_o] = merge_bytes(mem_array[mem_addr_o], mem_wdata_o, mem_wmask_o);
      end
      mem_rdata_i <= mem_array[mem_addr_o];
    end
    if (io_en_o) begin
      if (!io_array.exists(io_addr_o)) begin
        io_array[io_addr_o] = fill_word(io_addr_o);
      end
      if (io_we_o) begin
        io_array[io_addr_o] = merge_bytes(io_array[io_addr_o], io_wdata_o, io_wmask_o);
      end
      io_rdata_i <= io_array[io_addr_o];
    end
  end

  // Routing, handshakes and the response scoreboard.
  always @(posedge clk_i) begin
    a_accepted <= !reset_i && a_valid_i && a_ready_o;
    if (mem_en_o) begin
      expect_true(!in_io_window({mem_addr_o, 3'b000}),
                  $sformatf("memory BRAM hit inside IO window, word %h", mem_addr_o));
    end
    if (io_en_o) begin
      expect_true(in_io_window({io_addr_o, 3'b000}),
                  $sformatf("IO BRAM hit outside IO window, word %h", io_addr_o));
    end
    if (!reset_i && d_valid_o && d_ready_i) begin
      expect_true(pending[d_source_o],
                  $sformatf("response with source %0d not outstanding", d_source_o));
      expect_true(d_opcode_o == exp_opcode[d_source_o],
                  $sformatf("source %0d opcode %0d, expected %0d", d_source_o,
                            d_opcode_o, exp_opcode[d_source_o]));
      if (exp_opcode[d_source_o] == TL_ACCESS_ACK_DATA) begin
        expect_true(d_data_o == exp_data[d_source_o],
                    $sformatf("source %0d data %h, expected %h", d_source_o,
                              d_data_o, exp_data[d_source_o]));
      end
      pending[d_source_o] = 1'b0;
      resp_count++;
    end
  end

  // Back-pressure is drawn at the rising edge and applied at the falling edge.
  always @(posedge clk_i) begin
    ready_draw <= (($random(seed) & 3) != 0);
  end

  always @(negedge clk_i) begin
    d_ready_i = ready_draw;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
      $display("Errors: %0d check(s), %0d assertion(s)", check_errors,
               i_tl_bram_subsystem.i_chk.fail_count);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    logic [31:0] rnd;
    tl_addr_t    addr;
    tl_a_op_e    op;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    a_valid_i    = 1'b0;
    a_opcode_i   = TL_GET;
    a_address_i  = '0;
    a_mask_i     = '0;
    a_data_i     = '0;
    a_source_i   = '0;
    d_ready_i    = 1'b0;
    mem_rdata_i  = '0;
    io_rdata_i   = '0;
    next_tag     = '0;
    a_accepted   = 1'b0;
    ready_draw   = 1'b0;
    check_errors = 0;
    req_count    = 0;
    resp_count   = 0;
    cycle_count  = 0;
    seed         = 32'h3a8d_9609;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    expect_true(a_ready_o, "a_ready_o low after reset");

    send_request(TL_PUT_FULL_DATA, 56'h1000, 8'h00, 64'h0123_4567_89ab_cdef);
    send_request(TL_GET, 56'h1000, 8'hff, '0);
    // IO window, then the first address past it.
    send_request(TL_PUT_FULL_DATA, `IO_BASE + 56'h8, 8'hff, 64'hdead_beef_cafe_f00d);
    send_request(TL_GET, `IO_BASE + 56'h8, 8'hff, '0);
    send_request(TL_PUT_FULL_DATA, `IO_BASE + 56'h40, 8'hff, 64'h1111_2222_3333_4444);
    send_request(TL_GET, `IO_BASE + 56'h40, 8'hff, '0);
    send_request(TL_PUT_PARTIAL_DATA, 56'h1000, 8'h0f, 64'hffff_ffff_ffff_ffff);
    send_request(TL_GET, 56'h1000, 8'hff, '0);
    send_request(TL_PUT_PARTIAL_DATA, `IO_BASE + 56'h8, 8'ha5, '0);
    send_request(TL_GET, `IO_BASE + 56'h8, 8'hff, '0);

    // Memory and IO requests alternate back to back.
    for (int n = 0; n < 40; n++) begin
      rnd = $random(seed);
      if (n[0]) begin
        addr = `IO_BASE + {rnd[5:3], 3'b000};
      end else begin
        addr = 56'h2000 + {rnd[6:3], 3'b000};
      end
      case (rnd[9:8])
        2'd1:    op = TL_PUT_FULL_DATA;
        2'd2:    op = TL_PUT_PARTIAL_DATA;
        default: op = TL_GET;
      endcase
      send_request(op, addr, rnd[23:16], {$random(seed), $random(seed)});
    end

    while (resp_count != req_count) begin
      @(negedge clk_i);
    end
    repeat (10) @(negedge clk_i);
    expect_true(resp_count == req_count,
                $sformatf("%0d responses for %0d requests", resp_count, req_count));

    $display("Errors: %0d check(s), %0d assertion(s)", check_errors,
             i_tl_bram_subsystem.i_chk.fail_count);
    if (check_errors == 0 && i_tl_bram_subsystem.i_chk.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* sim/tl_bram_subsystem_chk.sv */
/*
 * Protocol assertions on the ports of the TileLink-UL to BRAM subsystem.
 */

`timescale 1ns/1ps

module tl_bram_subsystem_chk (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               a_valid_i,
  input  logic               a_ready_i,
  input  tl_pkg::tl_a_op_e   a_opcode_i,
  input  tl_pkg::tl_addr_t   a_address_i,
  input  tl_pkg::tl_mask_t   a_mask_i,
  input  tl_pkg::tl_data_t   a_data_i,
  input  tl_pkg::tl_source_t a_source_i,
  input  logic               d_valid_i,
  input  logic               d_ready_i,
  input  tl_pkg::tl_d_op_e   d_opcode_i,
  input  tl_pkg::tl_source_t d_source_i,
  input  tl_pkg::tl_data_t   d_data_i,
  input  logic               mem_en_i,
  input  logic               io_en_i
);

  int fail_count = 0;

  // A stalled response keeps its payload.
  d_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_opcode_i) &&
      $stable(d_source_i) && $stable(d_data_i))
  else begin
    fail_count++;
    $error("D payload changed while d_ready_i was low");
  end

  // The host keeps its request until it is taken.
  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    a_valid_i && !a_ready_i |=> a_valid_i && $stable(a_opcode_i) &&
      $stable(a_address_i) && $stable(a_mask_i) && $stable(a_data_i) &&
      $stable(a_source_i))
  else begin
    fail_count++;
    $error("A request changed before it was accepted");
  end

  one_bram: assert property (@(posedge clk_i) disable iff (reset_i)
    !(mem_en_i && io_en_i))
  else begin
    fail_count++;
    $error("memory and IO BRAM enabled in the same cycle");
  end

  reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> !mem_en_i && !io_en_i && !d_valid_i)
  else begin
    fail_count++;
    $error("enable or d_valid high right after reset");
  end

endmodule

bind tl_bram_subsystem tl_bram_subsystem_chk i_chk (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .a_valid_i   (a_valid_i),
  .a_ready_i   (a_ready_o),
  .a_opcode_i  (a_opcode_i),
  .a_address_i (a_address_i),
  .a_mask_i    (a_mask_i),
  .a_data_i    (a_data_i),
  .a_source_i  (a_source_i),
  .d_valid_i   (d_valid_o),
  .d_ready_i   (d_ready_i),
  .d_opcode_i  (d_opcode_o),
  .d_source_i  (d_source_o),
  .d_data_i    (d_data_o),
  .mem_en_i    (mem_en_o),
  .io_en_i     (io_en_o)
);

/* src/bram_pkg.sv */
/*
 * Memory-side types: BRAM word address, link select and adapter FSM states.
 */

`include "tl_defines.svh"

package bram_pkg;

  typedef logic [`BRAM_ADDR_WIDTH-1:0] bram_addr_t;

  typedef logic [0:0] link_idx_t;

  localparam link_idx_t LINK_MEM = 1'b0;
  localparam link_idx_t LINK_IO  = 1'b1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ_WAIT,
    ST_RESPOND
  } adapter_state_e;

endpackage

/* src/tl_adapter_bram.sv */
/*
 * TileLink-UL to block RAM adapter. Issues one BRAM access per request and
 * returns AccessAck or AccessAckData on the D channel.
 */

`timescale 1ns/1ps

`include "tl_defines.svh"

module tl_adapter_bram (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  a_valid_i,
  output logic                  a_ready_o,
  input  tl_pkg::tl_a_op_e      a_opcode_i,
  input  tl_pkg::tl_addr_t      a_address_i,
  input  tl_pkg::tl_mask_t      a_mask_i,
  input  tl_pkg::tl_data_t      a_data_i,
  input  tl_pkg::tl_source_t    a_source_i,
  output logic                  d_valid_o,
  input  logic                  d_ready_i,
  output tl_pkg::tl_d_op_e      d_opcode_o,
  output tl_pkg::tl_source_t    d_source_o,
  output tl_pkg::tl_data_t      d_data_o,

  output logic                  bram_en_o,
  output logic                  bram_we_o,
  output bram_pkg::bram_addr_t  bram_addr_o,
  output tl_pkg::tl_mask_t      bram_wmask_o,
  output tl_pkg::tl_data_t      bram_wdata_o,
  input  tl_pkg::tl_data_t      bram_rdata_i
);

  import tl_pkg::*;
  import bram_pkg::*;

  adapter_state_e state_q;
  tl_d_op_e       d_opcode_q;
  tl_source_t     source_q;
  tl_data_t       rdata_q;

  logic a_fire;
  logic is_get;

  assign a_ready_o = (state_q == ST_IDLE);
  assign a_fire    = a_valid_i && a_ready_o;
  assign is_get    = (a_opcode_i == TL_GET);

  // Strobes are live only in the accept cycle.
  assign bram_en_o    = a_fire;
  assign bram_we_o    = a_fire && !is_get;
  assign bram_addr_o  = a_address_i[`TL_ADDR_WIDTH-1:3];
  assign bram_wmask_o = (a_opcode_i == TL_PUT_FULL_DATA) ? '1 : a_mask_i;
  assign bram_wdata_o = a_data_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (a_fire) begin
            state_q <= ST_READ_WAIT;
          end
        end
        ST_READ_WAIT: begin
          state_q <= ST_RESPOND;
        end
        ST_RESPOND: begin
          if (d_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      source_q   <= a_source_i;
      d_opcode_q <= is_get ? TL_ACCESS_ACK_DATA : TL_ACCESS_ACK;
    end
    // BRAM output is valid the cycle after the access.
    if (state_q == ST_READ_WAIT) begin
      rdata_q <= bram_rdata_i;
    end
  end

  assign d_valid_o  = (state_q == ST_RESPOND);
  assign d_opcode_o = d_opcode_q;
  assign d_source_o = source_q;
  assign d_data_o   = rdata_q;

endmodule

/* src/tl_bram_subsystem.sv */
/*
 * Memory side of the processor wrapper: a socket feeding a memory BRAM
 * adapter and an IO BRAM adapter.
 */

`timescale 1ns/1ps

`include "tl_defines.svh"

module tl_bram_subsystem (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  a_valid_i,
  output logic                  a_ready_o,
  input  tl_pkg::tl_a_op_e      a_opcode_i,
  input  tl_pkg::tl_addr_t      a_address_i,
  input  tl_pkg::tl_mask_t      a_mask_i,
  input  tl_pkg::tl_data_t      a_data_i,
  input  tl_pkg::tl_source_t    a_source_i,
  output logic                  d_valid_o,
  input  logic                  d_ready_i,
  output tl_pkg::tl_d_op_e      d_opcode_o,
  output tl_pkg::tl_source_t    d_source_o,
  output tl_pkg::tl_data_t      d_data_o,

  output logic                  mem_en_o,
  output logic                  mem_we_o,
  output bram_pkg::bram_addr_t  mem_addr_o,
  output tl_pkg::tl_mask_t      mem_wmask_o,
  output tl_pkg::tl_data_t      mem_wdata_o,
  input  tl_pkg::tl_data_t      mem_rdata_i,

  output logic                  io_en_o,
  output logic                  io_we_o,
  output bram_pkg::bram_addr_t  io_addr_o,
  output tl_pkg::tl_mask_t      io_wmask_o,
  output tl_pkg::tl_data_t      io_wdata_o,
  input  tl_pkg::tl_data_t      io_rdata_i
);

  import tl_pkg::*;

  logic       mem_a_valid;
  logic       mem_a_ready;
  tl_a_op_e   mem_a_opcode;
  tl_addr_t   mem_a_address;
  tl_mask_t   mem_a_mask;
  tl_data_t   mem_a_data;
  tl_source_t mem_a_source;
  logic       mem_d_valid;
  logic       mem_d_ready;
  tl_d_op_e   mem_d_opcode;
  tl_source_t mem_d_source;
  tl_data_t   mem_d_data;

  logic       io_a_valid;
  logic       io_a_ready;
  tl_a_op_e   io_a_opcode;
  tl_addr_t   io_a_address;
  tl_mask_t   io_a_mask;
  tl_data_t   io_a_data;
  tl_source_t io_a_source;
  logic       io_d_valid;
  logic       io_d_ready;
  tl_d_op_e   io_d_opcode;
  tl_source_t io_d_source;
  tl_data_t   io_d_data;

  tl_socket_1n i_socket (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .a_valid_i       (a_valid_i),
    .a_ready_o       (a_ready_o),
    .a_opcode_i      (a_opcode_i),
    .a_address_i     (a_address_i),
    .a_mask_i        (a_mask_i),
    .a_data_i        (a_data_i),
    .a_source_i      (a_source_i),
    .d_valid_o       (d_valid_o),
    .d_ready_i       (d_ready_i),
    .d_opcode_o      (d_opcode_o),
    .d_source_o      (d_source_o),
    .d_data_o        (d_data_o),
    .mem_a_valid_o   (mem_a_valid),
    .mem_a_ready_i   (mem_a_ready),
    .mem_a_opcode_o  (mem_a_opcode),
    .mem_a_address_o (mem_a_address),
    .mem_a_mask_o    (mem_a_mask),
    .mem_a_data_o    (mem_a_data),
    .mem_a_source_o  (mem_a_source),
    .mem_d_valid_i   (mem_d_valid),
    .mem_d_ready_o   (mem_d_ready),
    .mem_d_opcode_i  (mem_d_opcode),
    .mem_d_source_i  (mem_d_source),
    .mem_d_data_i    (mem_d_data),
    .io_a_valid_o    (io_a_valid),
    .io_a_ready_i    (io_a_ready),
    .io_a_opcode_o   (io_a_opcode),
    .io_a_address_o  (io_a_address),
    .io_a_mask_o     (io_a_mask),
    .io_a_data_o     (io_a_data),
    .io_a_source_o   (io_a_source),
    .io_d_valid_i    (io_d_valid),
    .io_d_ready_o    (io_d_ready),
    .io_d_opcode_i   (io_d_opcode),
    .io_d_source_i   (io_d_source),
    .io_d_data_i     (io_d_data)
  );

  tl_adapter_bram i_mem_adapter (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .a_valid_i    (mem_a_valid),
    .a_ready_o    (mem_a_ready),
    .a_opcode_i   (mem_a_opcode),
    .a_address_i  (mem_a_address),
    .a_mask_i     (mem_a_mask),
    .a_data_i     (mem_a_data),
    .a_source_i   (mem_a_source),
    .d_valid_o    (mem_d_valid),
    .d_ready_i    (mem_d_ready),
    .d_opcode_o   (mem_d_opcode),
    .d_source_o   (mem_d_source),
    .d_data_o     (mem_d_data),
    .bram_en_o    (mem_en_o),
    .bram_we_o    (mem_we_o),
    .bram_addr_o  (mem_addr_o),
    .bram_wmask_o (mem_wmask_o),
    .bram_wdata_o (mem_wdata_o),
    .bram_rdata_i (mem_rdata_i)
  );

  tl_adapter_bram i_io_adapter (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .a_valid_i    (io_a_valid),
    .a_ready_o    (io_a_ready),
    .a_opcode_i   (io_a_opcode),
    .a_address_i  (io_a_address),
    .a_mask_i     (io_a_mask),
    .a_data_i     (io_a_data),
    .a_source_i   (io_a_source),
    .d_valid_o    (io_d_valid),
    .d_ready_i    (io_d_ready),
    .d_opcode_o   (io_d_opcode),
    .d_source_o   (io_d_source),
    .d_data_o     (io_d_data),
    .bram_en_o    (io_en_o),
    .bram_we_o    (io_we_o),
    .bram_addr_o  (io_addr_o),
    .bram_wmask_o (io_wmask_o),
    .bram_wdata_o (io_wdata_o),
    .bram_rdata_i (io_rdata_i)
  );

endmodule

/* src/tl_defines.svh */
/*
 * Width and address-map macros for the TileLink-UL to BRAM subsystem.
 */

`ifndef TL_DEFINES_SVH
`define TL_DEFINES_SVH

// Bus widths.
`define TL_DATA_WIDTH   64
`define TL_ADDR_WIDTH   56
`define TL_SOURCE_WIDTH 4

// Word address of a 64-bit BRAM word.
`define BRAM_ADDR_WIDTH 53

// Anything outside the single IO window goes to main memory.
`define IO_BASE         56'h8001_0000
`define IO_MASK         56'h0000_003f

`endif

/* src/tl_pkg.sv */
/*
 * TileLink-UL bus protocol types: payload widths and A/D channel opcodes.
 */

`include "tl_defines.svh"

package tl_pkg;

  typedef logic [`TL_DATA_WIDTH-1:0]   tl_data_t;
  typedef logic [`TL_ADDR_WIDTH-1:0]   tl_addr_t;
  typedef logic [`TL_DATA_WIDTH/8-1:0] tl_mask_t;
  typedef logic [`TL_SOURCE_WIDTH-1:0] tl_source_t;

  // A channel opcodes with their TileLink encodings.
  typedef enum logic [2:0] {
    TL_PUT_FULL_DATA    = 3'd0,
    TL_PUT_PARTIAL_DATA = 3'd1,
    TL_GET              = 3'd4
  } tl_a_op_e;

  // D channel opcodes.
  typedef enum logic [2:0] {
    TL_ACCESS_ACK      = 3'd0,
    TL_ACCESS_ACK_DATA = 3'd1
  } tl_d_op_e;

endpackage

/* src/tl_socket_1n.sv */
/*
 * One-to-two TileLink-UL socket. Registers each request, routes it to the
 * memory or IO link by address, and merges the two D channels round-robin.
 */

`timescale 1ns/1ps

`include "tl_defines.svh"

module tl_socket_1n (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  a_valid_i,
  output logic                  a_ready_o,
  input  tl_pkg::tl_a_op_e      a_opcode_i,
  input  tl_pkg::tl_addr_t      a_address_i,
  input  tl_pkg::tl_mask_t      a_mask_i,
  input  tl_pkg::tl_data_t      a_data_i,
  input  tl_pkg::tl_source_t    a_source_i,
  output logic                  d_valid_o,
  input  logic                  d_ready_i,
  output tl_pkg::tl_d_op_e      d_opcode_o,
  output tl_pkg::tl_source_t    d_source_o,
  output tl_pkg::tl_data_t      d_data_o,

  output logic                  mem_a_valid_o,
  input  logic                  mem_a_ready_i,
  output tl_pkg::tl_a_op_e      mem_a_opcode_o,
  output tl_pkg::tl_addr_t      mem_a_address_o,
  output tl_pkg::tl_mask_t      mem_a_mask_o,
  output tl_pkg::tl_data_t      mem_a_data_o,
  output tl_pkg::tl_source_t    mem_a_source_o,
  input  logic                  mem_d_valid_i,
  output logic                  mem_d_ready_o,
  input  tl_pkg::tl_d_op_e      mem_d_opcode_i,
  input  tl_pkg::tl_source_t    mem_d_source_i,
  input  tl_pkg::tl_data_t      mem_d_data_i,

  output logic                  io_a_valid_o,
  input  logic                  io_a_ready_i,
  output tl_pkg::tl_a_op_e      io_a_opcode_o,
  output tl_pkg::tl_addr_t      io_a_address_o,
  output tl_pkg::tl_mask_t      io_a_mask_o,
  output tl_pkg::tl_data_t      io_a_data_o,
  output tl_pkg::tl_source_t    io_a_source_o,
  input  logic                  io_d_valid_i,
  output logic                  io_d_ready_o,
  input  tl_pkg::tl_d_op_e      io_d_opcode_i,
  input  tl_pkg::tl_source_t    io_d_source_i,
  input  tl_pkg::tl_data_t      io_d_data_i
);

  import tl_pkg::*;
  import bram_pkg::*;

  logic       req_valid_q;
  link_idx_t  req_link_q;
  tl_a_op_e   req_opcode_q;
  tl_addr_t   req_address_q;
  tl_mask_t   req_mask_q;
  tl_data_t   req_data_q;
  tl_source_t req_source_q;

  link_idx_t  a_link;
  logic       link_ready;
  logic       a_fire;

  link_idx_t  d_grant;
  link_idx_t  rr_q;

  // Address decode against the IO window.
  assign a_link = ((a_address_i & ~`IO_MASK) == `IO_BASE) ? LINK_IO : LINK_MEM;

  assign link_ready = (req_link_q == LINK_IO) ? io_a_ready_i : mem_a_ready_i;
  assign a_ready_o  = !req_valid_q || link_ready;
  assign a_fire     = a_valid_i && a_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_valid_q <= 1'b0;
    end else if (a_fire) begin
      req_valid_q <= 1'b1;
    end else if (link_ready) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      req_link_q    <= a_link;
      req_opcode_q  <= a_opcode_i;
      req_address_q <= a_address_i;
      req_mask_q    <= a_mask_i;
      req_data_q    <= a_data_i;
      req_source_q  <= a_source_i;
    end
  end

  // Payload goes to both links and only the chosen one sees valid.
  assign mem_a_valid_o   = req_valid_q && (req_link_q == LINK_MEM);
  assign mem_a_opcode_o  = req_opcode_q;
  assign mem_a_address_o = req_address_q;
  assign mem_a_mask_o    = req_mask_q;
  assign mem_a_data_o    = req_data_q;
  assign mem_a_source_o  = req_source_q;

  assign io_a_valid_o    = req_valid_q && (req_link_q == LINK_IO);
  assign io_a_opcode_o   = req_opcode_q;
  assign io_a_address_o  = req_address_q;
  assign io_a_mask_o     = req_mask_q;
  assign io_a_data_o     = req_data_q;
  assign io_a_source_o   = req_source_q;

  // Under contention the pointer picks; a lone valid link always wins.
  always_comb begin
    if (mem_d_valid_i && io_d_valid_i) begin
      d_grant = rr_q;
    end else if (io_d_valid_i) begin
      d_grant = LINK_IO;
    end else begin
      d_grant = LINK_MEM;
    end
  end

  // A stalled grant stays preferred so the D payload holds.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q <= LINK_MEM;
    end else if (d_valid_o) begin
      rr_q <= d_ready_i ? ~d_grant : d_grant;
    end
  end

  assign d_valid_o     = mem_d_valid_i || io_d_valid_i;
  assign mem_d_ready_o = d_ready_i && (d_grant == LINK_MEM);
  assign io_d_ready_o  = d_ready_i && (d_grant == LINK_IO);

  assign d_opcode_o = (d_grant == LINK_IO) ? io_d_opcode_i : mem_d_opcode_i;
  assign d_source_o = (d_grant == LINK_IO) ? io_d_source_i : mem_d_source_i;
  assign d_data_o   = (d_grant == LINK_IO) ? io_d_data_i   : mem_d_data_i;

endmodule
